// File: hdl/scaler_config.svh
`ifndef SCALER_CONFIG_SVH
`define SCALER_CONFIG_SVH

// bits per pixel component
`define SCALER_PIXEL_WIDTH 12

// coefficient bits, 1.0 sits at bit COE_WIDTH-2
`define SCALER_COE_WIDTH 10

`define SCALER_LINE_MAX 1024

// row position fraction, one input line is 1 << FRAC_BITS
`define SCALER_FRAC_BITS 12
`define SCALER_PHASE_BITS 6 // top fraction bits into the table

`define SCALER_SPARSE 2 // idle cycles between output pixels

`endif

// File: hdl/video_pkg.sv
`default_nettype none

`include "scaler_config.svh"

package video_pkg;

    typedef logic [`SCALER_PIXEL_WIDTH-1:0]       pixel_t;
    typedef logic [$clog2(`SCALER_LINE_MAX)-1:0]  line_addr_t; // pixel index in a line
    typedef logic [15:0]                          line_size_t;

endpackage

`default_nettype wire

// File: hdl/scaler_pkg.sv
`default_nettype none

`include "scaler_config.svh"

package scaler_pkg;

    typedef logic [23:0] pos_t;  // unsigned fixed point row position
    typedef logic [15:0] step_t;
    typedef logic [11:0] row_t;
    typedef logic [`SCALER_PHASE_BITS-1:0] phase_t;
    typedef logic [`SCALER_COE_WIDTH-1:0]  coe_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        LINE_GEN
    } vctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/video_if.sv
`timescale 1ns/10ps
`default_nettype none

interface video_if;

    import video_pkg::*;

    pixel_t pix;
    logic   de;
    logic   hs; // first pixel of a line
    logic   vs; // first pixel of a frame, comes with hs

    modport src (output pix, de, hs, vs);
    modport snk (input pix, de, hs, vs);

endinterface

`default_nettype wire

// File: hdl/line_rd_if.sv
`timescale 1ns/10ps
`default_nettype none

interface line_rd_if;

    import video_pkg::*;
    import scaler_pkg::*;

    logic       rd_en;
    line_addr_t addr;
    row_t       row;

    // rows row-1 .. row+2, two cycles after rd_en
    pixel_t     taps [4];

    modport ctrl  (output rd_en, addr, row, input taps);
    modport store (input rd_en, addr, row, output taps);

endinterface

`default_nettype wire

// File: hdl/line_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module line_store (
    input  logic                  clk,
    input  logic                  rst_n_i,
    video_if.snk                  vin,
    input  video_pkg::line_size_t line_size_i,
    line_rd_if.store              rd,
    output scaler_pkg::row_t      lines_done_o,
    output logic                  frame_start_o
);

    import video_pkg::*;
    import scaler_pkg::*;

    localparam int SLOTS = 5;

    pixel_t     mem [SLOTS][`SCALER_LINE_MAX];
    line_size_t wr_col;
    logic [2:0] wr_slot;
    row_t       done_cnt;
    line_size_t cur_col;
    logic [2:0] cur_slot;
    row_t       cur_done;
    logic       line_end;
    logic [2:0] base_slot;
    pixel_t     slot_q [SLOTS];
    logic [2:0] base_q;
    logic       top_q;
    logic       rd_q;

    function automatic logic [2:0] ring_add(input logic [2:0] b, input int i);
        logic [3:0] s;
        s = {1'b0, b} + 4'(i);
        return (s >= 4'd5) ? 3'(s - 4'd5) : s[2:0];
    endfunction

    // line and frame starts take effect on their own pixel
    assign cur_col  = vin.hs ? '0 : wr_col;
    assign cur_slot = vin.vs ? '0 : wr_slot;
    assign cur_done = vin.vs ? '0 : done_cnt;
    assign line_end = vin.de && (cur_col == line_size_i - 16'd1);

    assign base_slot    = 3'(({1'b0, rd.row} + 13'd4) % 13'd5); // slot of row-1
    assign lines_done_o = done_cnt;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_col        <= '0;
            wr_slot       <= '0;
            done_cnt      <= '0;
            frame_start_o <= 1'b0;
            rd_q          <= 1'b0;
        end else begin
            frame_start_o <= vin.de & vin.vs;
            rd_q          <= rd.rd_en;
            if (vin.de) begin
                wr_col   <= cur_col + 16'd1;
                wr_slot  <= cur_slot;
                done_cnt <= cur_done;
                if (line_end) begin
                    wr_slot  <= (cur_slot == 3'd4) ? '0 : cur_slot + 3'd1;
                    done_cnt <= cur_done + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vin.de) begin
            mem[cur_slot][line_addr_t'(cur_col)] <= vin.pix;
        end
        if (rd.rd_en) begin
            for (int s = 0; s < SLOTS; s++) begin
                slot_q[s] <= mem[s][rd.addr];
            end
            base_q <= base_slot;
            top_q  <= (rd.row == '0);
        end
        if (rd_q) begin
            for (int i = 0; i < 4; i++) begin
                rd.taps[i] <= slot_q[ring_add(base_q, i)];
            end
            if (top_q) begin
                rd.taps[0] <= '0; // nothing above the frame
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/cubic_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module cubic_table (
    input  logic               clk,
    input  scaler_pkg::phase_t phase_i,
    output scaler_pkg::coe_t   coe_o [4]
);

    import scaler_pkg::*;

    localparam int     PHASES = 1 << `SCALER_PHASE_BITS;
    localparam longint ONE    = 1 << (`SCALER_COE_WIDTH - 2);

    typedef coe_t [3:0]            coe_set_t;
    typedef coe_set_t [PHASES-1:0] rom_t;

    // catmull-rom weights with t = p/n, outer taps stored as magnitudes
    function automatic rom_t build_rom();
        rom_t   rom;
        longint n;
        longint p;
        longint den;
        longint num [4];
        n   = PHASES;
        den = 2 * n * n * n;
        for (int i = 0; i < PHASES; i++) begin
            p      = i;
            num[0] = p*p*p - 2*p*p*n + p*n*n;
            num[1] = 3*p*p*p - 5*p*p*n + 2*n*n*n;
            num[2] = -3*p*p*p + 4*p*p*n + p*n*n;
            num[3] = p*p*n - p*p*p;
            for (int k = 0; k < 4; k++) begin
                rom[i][k] = coe_t'((num[k] * ONE + den / 2) / den); // round to nearest
            end
        end
        return rom;
    endfunction

    localparam rom_t ROM = build_rom();

    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            coe_o[k] <= ROM[phase_i][k];
        end
    end

endmodule

`default_nettype wire

// File: hdl/vscale_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module vscale_ctrl (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  scaler_pkg::step_t     scale_step_i,
    input  video_pkg::line_size_t line_size_i,
    input  scaler_pkg::row_t      lines_done_i,
    input  logic                  frame_start_i,
    line_rd_if.ctrl               rd,
    output scaler_pkg::phase_t    phase_o,
    output logic                  line_first_o,
    output logic                  frame_first_o
);

    import video_pkg::*;
    import scaler_pkg::*;

    localparam int FRAC     = `SCALER_FRAC_BITS;
    localparam int SPARSE_W = $clog2(`SCALER_SPARSE + 2);
    localparam logic [SPARSE_W-1:0] SPARSE_LAST = SPARSE_W'(`SCALER_SPARSE);

    vctrl_state_t        state;
    pos_t                pos;
    logic [SPARSE_W-1:0] sparse_cnt;
    line_size_t          addr_cnt;
    row_t                pos_row;
    phase_t              pos_phase;
    logic                src_ready;
    logic                issue;

    assign pos_row   = pos[FRAC +: $bits(row_t)];
    assign pos_phase = pos[FRAC-1 -: $bits(phase_t)];

    // rows n-1 .. n+2 all stored
    assign src_ready = {1'b0, lines_done_i} >= ({1'b0, pos_row} + 13'd3);
    assign issue     = (state == LINE_GEN) && (sparse_cnt == '0) && (addr_cnt != line_size_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= IDLE;
            pos        <= '0;
            sparse_cnt <= '0;
            addr_cnt   <= '0;
            rd.rd_en   <= 1'b0;
        end else begin
            rd.rd_en <= issue;
            case (state)
                IDLE: begin
                    if (src_ready) state <= SETUP;
                end
                SETUP: begin
                    sparse_cnt <= '0;
                    addr_cnt   <= '0;
                    state      <= LINE_GEN;
                end
                LINE_GEN: begin
                    sparse_cnt <= (sparse_cnt == SPARSE_LAST) ? '0 : sparse_cnt + 1'b1;
                    if (issue) addr_cnt <= addr_cnt + 16'd1;
                    if ((sparse_cnt == SPARSE_LAST) && (addr_cnt == line_size_i)) begin
                        pos   <= pos + pos_t'(scale_step_i); // next output line
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (frame_start_i) begin
                pos   <= '0;
                state <= IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SETUP) rd.row <= pos_row;
        if (issue) begin
            rd.addr       <= line_addr_t'(addr_cnt);
            phase_o       <= pos_phase;
            line_first_o  <= (addr_cnt == '0);
            frame_first_o <= (addr_cnt == '0) && (pos == '0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/cubic_filter.sv
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module cubic_filter (
    input  logic               clk,
    input  logic               rst_n_i,
    input  video_pkg::pixel_t  taps_i [4],
    input  scaler_pkg::phase_t phase_i,
    input  logic               pix_strobe_i,
    input  logic               line_first_i,
    input  logic               frame_first_i,
    video_if.src               vout
);

    import video_pkg::*;
    import scaler_pkg::*;

    localparam int PIX_W  = `SCALER_PIXEL_WIDTH;
    localparam int COE_W  = `SCALER_COE_WIDTH;
    localparam int MULT_W = PIX_W + COE_W;
    localparam int SUM_W  = MULT_W + 2;
    localparam int LAT    = 5; // rd_en to de
    localparam logic signed [SUM_W-1:0] ROUND   = SUM_W'(1 << (COE_W - 3));
    localparam logic signed [SUM_W-1:0] PIX_MAX = SUM_W'((1 << PIX_W) - 1);

    phase_t                  phase_q;
    coe_t                    coe [4];
    logic [MULT_W-1:0]       mult [4];
    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] sum_sh;
    logic [LAT-1:0]          de_sr;
    logic [LAT-1:0]          hs_sr;
    logic [LAT-1:0]          vs_sr;

    cubic_table u_table (
        .clk     (clk),
        .phase_i (phase_q),
        .coe_o   (coe)
    );

    assign sum_sh = sum >>> (COE_W - 2);

    always_ff @(posedge clk) begin
        phase_q <= phase_i; // table output lines up with the taps
        for (int k = 0; k < 4; k++) begin
            mult[k] <= coe[k] * taps_i[k];
        end
        sum <= SUM_W'(mult[1]) + SUM_W'(mult[2])
             - SUM_W'(mult[0]) - SUM_W'(mult[3]) + ROUND;
        if (sum < 0) vout.pix <= '0;
        else if (sum_sh > PIX_MAX) vout.pix <= pixel_t'(PIX_MAX);
        else vout.pix <= pixel_t'(sum_sh);
    end

    // one bit per pixel in flight
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_sr <= '0;
            hs_sr <= '0;
            vs_sr <= '0;
        end else begin
            de_sr <= {de_sr[LAT-2:0], pix_strobe_i};
            hs_sr <= {hs_sr[LAT-2:0], pix_strobe_i & line_first_i};
            vs_sr <= {vs_sr[LAT-2:0], pix_strobe_i & frame_first_i};
        end
    end

    assign vout.de = de_sr[LAT-1];
    assign vout.hs = hs_sr[LAT-1];
    assign vout.vs = vs_sr[LAT-1];

endmodule

`default_nettype wire

// File: hdl/vscaler_top.sv
`timescale 1ns/10ps
`default_nettype none

module vscaler_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  scaler_pkg::step_t     scale_step_i,
    input  video_pkg::line_size_t line_size_i,
    input  video_pkg::pixel_t     di_i,
    input  logic                  de_i,
    input  logic                  hs_i,
    input  logic                  vs_i,
    output video_pkg::pixel_t     do_o,
    output logic                  de_o,
    output logic                  hs_o,
    output logic                  vs_o
);

    import scaler_pkg::*;

    row_t   lines_done;
    logic   frame_start;
    phase_t phase;
    logic   line_first;
    logic   frame_first;

    video_if   vin ();
    video_if   vout ();
    line_rd_if rd ();

    assign vin.pix = di_i;
    assign vin.de  = de_i;
    assign vin.hs  = hs_i;
    assign vin.vs  = vs_i;

    line_store u_store (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .vin           (vin.snk),
        .line_size_i   (line_size_i),
        .rd            (rd.store),
        .lines_done_o  (lines_done),
        .frame_start_o (frame_start)
    );

    vscale_ctrl u_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .scale_step_i  (scale_step_i),
        .line_size_i   (line_size_i),
        .lines_done_i  (lines_done),
        .frame_start_i (frame_start),
        .rd            (rd.ctrl),
        .phase_o       (phase),
        .line_first_o  (line_first),
        .frame_first_o (frame_first)
    );

    cubic_filter u_filter (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .taps_i        (rd.taps),
        .phase_i       (phase),
        .pix_strobe_i  (rd.rd_en),
        .line_first_i  (line_first),
        .frame_first_i (frame_first),
        .vout          (vout.src)
    );

    assign do_o = vout.pix;
    assign de_o = vout.de;
    assign hs_o = vout.hs;
    assign vs_o = vout.vs;

endmodule

`default_nettype wire

// File: testbench/vscaler_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module vscaler_props (
    input logic clk,
    input logic rst_n_i,
    input logic de_i,
    input logic hs_i,
    input logic vs_i
);

    // pixels leave at most once per SPARSE+1 cycles
    for (genvar i = 1; i <= `SCALER_SPARSE; i++) begin : g_spacing
        a_de_spacing: assert property (@(posedge clk) disable iff (!rst_n_i)
            de_i |-> !$past(de_i, i))
            else $error("de_o pulses closer than %0d cycles", `SCALER_SPARSE + 1);
    end

    a_hs_de: assert property (@(posedge clk) disable iff (!rst_n_i) hs_i |-> de_i)
        else $error("hs_o without de_o");

    a_vs_de: assert property (@(posedge clk) disable iff (!rst_n_i) vs_i |-> de_i)
        else $error("vs_o without de_o");

endmodule

`default_nettype wire

// File: testbench/vscaler_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "scaler_config.svh"

module vscaler_tb;

    import video_pkg::*;
    import scaler_pkg::*;

    localparam int PW       = `SCALER_PIXEL_WIDTH;
    localparam int FRAC     = `SCALER_FRAC_BITS;
    localparam int WIDTH    = 24;
    localparam int HEIGHT   = 8;
    localparam int FRAMES   = 4;
    localparam int RST_CYC  = 5;
    localparam int LAT      = 5;
    localparam int LINE_CYC = (`SCALER_SPARSE + 1) * WIDTH + 8; // one output line
    localparam int GAP      = 2 * LINE_CYC + 10; // up to two output lines per input line
    localparam int LIMIT    = FRAMES * (HEIGHT * (WIDTH + GAP) + LAT + 100) + 4 * RST_CYC;
    localparam int PIX_MAX  = (1 << PW) - 1;
    localparam int ONE      = 1 << (`SCALER_COE_WIDTH - 2);

    logic       clk;
    logic       rst_n_i;
    step_t      scale_step_i;
    line_size_t line_size_i;
    pixel_t     di_i;
    logic       de_i;
    logic       hs_i;
    logic       vs_i;
    pixel_t     do_o;
    logic       de_o;
    logic       hs_o;
    logic       vs_o;

    logic [15:0]   lfsr;
    int            img [HEIGHT][WIDTH];
    logic [PW+1:0] exp_q [$]; // {vs, hs, pix}
    int            exp_lines;
    int            lines_seen;
    int            vs_seen;
    int            clamp_lo;
    int            clamp_hi;
    int            value_errs;
    int            other_errs;
    int            cycles;

    vscaler_top UUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .scale_step_i (scale_step_i),
        .line_size_i  (line_size_i),
        .di_i         (di_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .do_o         (do_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

    bind cubic_filter vscaler_props u_props (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .de_i    (vout.de),
        .hs_i    (vout.hs),
        .vs_i    (vout.vs)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // catmull-rom weight for tap k, outer taps as magnitudes
    function automatic int coef(input int k, input int ph);
        real t;
        real w;
        t = real'(ph) / real'(1 << `SCALER_PHASE_BITS);
        case (k)
            0:       w = (t*t*t - 2.0*t*t + t) / 2.0;
            1:       w = (3.0*t*t*t - 5.0*t*t + 2.0) / 2.0;
            2:       w = (-3.0*t*t*t + 4.0*t*t + t) / 2.0;
            default: w = (t*t - t*t*t) / 2.0;
        endcase
        return $rtoi(w * real'(ONE) + 0.5);
    endfunction

    function automatic int row_px(input int r, input int x);
        return (r < 0) ? 0 : img[r][x]; // above the frame is black
    endfunction

    function automatic int model_px(input int n, input int ph, input int x);
        int acc;
        acc = coef(1, ph) * row_px(n, x) + coef(2, ph) * row_px(n + 1, x)
            - coef(0, ph) * row_px(n - 1, x) - coef(3, ph) * row_px(n + 2, x)
            + (1 << (`SCALER_COE_WIDTH - 3));
        acc = acc >>> (`SCALER_COE_WIDTH - 2);
        if (acc < 0) begin
            clamp_lo++;
            return 0;
        end
        if (acc > PIX_MAX) begin
            clamp_hi++;
            return PIX_MAX;
        end
        return acc;
    endfunction

    task automatic build_expected(input int step);
        int p;
        int n;
        int ph;
        int v;
        p         = 0;
        exp_lines = 0;
        // lines whose lowest tap is past the frame are dropped
        while ((p >> FRAC) + 2 <= HEIGHT - 1) begin
            n  = p >> FRAC;
            ph = (p >> (FRAC - `SCALER_PHASE_BITS)) % (1 << `SCALER_PHASE_BITS);
            for (int x = 0; x < WIDTH; x++) begin
                v = model_px(n, ph, x);
                exp_q.push_back({(p == 0 && x == 0), (x == 0), pixel_t'(v)});
            end
            exp_lines++;
            p += step;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        next_cycle();
    endtask

    task automatic send_frame(input int step, input bit banded);
        for (int r = 0; r < HEIGHT; r++) begin
            for (int x = 0; x < WIDTH; x++) begin
                if (banded) begin
                    img[r][x] = (r % 4 < 2) ? PIX_MAX - rand_bits(6) : rand_bits(6); // 2 bright, 2 dark
                end else begin
                    img[r][x] = rand_bits(PW);
                end
            end
        end
        clamp_lo   = 0;
        clamp_hi   = 0;
        lines_seen = 0;
        vs_seen    = 0;
        build_expected(step);
        scale_step_i = step_t'(step);
        for (int r = 0; r < HEIGHT; r++) begin
            for (int x = 0; x < WIDTH; x++) begin
                di_i = pixel_t'(img[r][x]);
                de_i = 1'b1;
                hs_i = (x == 0);
                vs_i = (x == 0 && r == 0);
                next_cycle();
            end
            de_i = 1'b0;
            hs_i = 1'b0;
            vs_i = 1'b0;
            repeat (GAP) next_cycle(); // pending output lines drain here
        end
        while (exp_q.size() != 0) next_cycle();
        assert (lines_seen == exp_lines) else begin
            value_errs++;
            $display("CHECK FAILED t=%0t hs_o count got %0d expected %0d",
                     $time, lines_seen, exp_lines);
        end
        assert (vs_seen == 1) else begin
            value_errs++;
            $display("CHECK FAILED t=%0t vs_o count got %0d expected 1", $time, vs_seen);
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        logic [PW+1:0] e;
        if (!rst_n_i) begin
            assert (!de_o) else begin
                other_errs++;
                $display("de_o went high during reset at t=%0t", $time);
            end
        end else if (de_o) begin
            if (hs_o) lines_seen++;
            if (vs_o) vs_seen++;
            assert (exp_q.size() != 0) else begin
                other_errs++;
                $display("output pixel at t=%0t with none expected", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (do_o == e[PW-1:0]) else begin
                    value_errs++;
                    $display("CHECK FAILED t=%0t do_o got %0d expected %0d",
                             $time, do_o, e[PW-1:0]);
                end
                assert (hs_o == e[PW]) else begin
                    value_errs++;
                    $display("CHECK FAILED t=%0t hs_o got %0b expected %0b", $time, hs_o, e[PW]);
                end
                assert (vs_o == e[PW+1]) else begin
                    value_errs++;
                    $display("CHECK FAILED t=%0t vs_o got %0b expected %0b",
                             $time, vs_o, e[PW+1]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, output frames never completed", cycles);
            $display("errors: %0d value, %0d other", value_errs, other_errs);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        lfsr         = 16'd96;
        value_errs   = 0;
        other_errs   = 0;
        cycles       = 0;
        lines_seen   = 0;
        vs_seen      = 0;
        rst_n_i      = 1'b0;
        scale_step_i = '0;
        line_size_i  = line_size_t'(WIDTH);
        di_i         = '0;
        de_i         = 1'b0;
        hs_i         = 1'b0;
        vs_i         = 1'b0;
        apply_reset();
        send_frame((3 << FRAC) / 4, 1'b0); // upscale
        send_frame((3 << FRAC) / 2, 1'b0); // downscale, skips rows
        send_frame((3 << FRAC) / 4, 1'b1);
        assert (clamp_lo > 0 && clamp_hi > 0) else begin
            other_errs++;
            $display("banded frame did not reach both clamp limits");
        end
        apply_reset();
        send_frame((3 << FRAC) / 4, 1'b0);
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/video_pkg.sv
hdl/scaler_pkg.sv
hdl/video_if.sv
hdl/line_rd_if.sv
hdl/line_store.sv
hdl/cubic_table.sv
hdl/vscale_ctrl.sv
hdl/cubic_filter.sv
hdl/vscaler_top.sv
testbench/vscaler_props.sv
testbench/vscaler_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module vscaler_tb -Mdir obj_dir
	./obj_dir/Vvscaler_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then echo "simulation stopped early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
